// ==== common/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

    localparam int DATA_W    = 64;
    localparam int ADDR_W    = 32;
    localparam int REG_IDX_W = 2;

    // Access size, byte count is 1 << size
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_WORD  = 2'd1,
        SZ_DWORD = 2'd2,
        SZ_QWORD = 2'd3
    } opsize_e;

    typedef enum logic [2:0] {
        SRC_NONE = 3'd0,
        SRC_REG  = 3'd1,
        SRC_SEG  = 3'd2,
        SRC_MEM1 = 3'd3,
        SRC_EIP  = 3'd4,
        SRC_IMM  = 3'd5
    } op_src_e;

    typedef enum logic [1:0] {
        DEST_NONE = 2'd0,
        DEST_REG  = 2'd1,
        DEST_SEG  = 2'd2,
        DEST_MEM  = 2'd3
    } dest_kind_e;

    function automatic logic [3:0] size_bytes(opsize_e sz);
        return 4'd1 << sz;
    endfunction

endpackage

`default_nettype wire

// ==== common/mem_fault_pkg.sv ====
`default_nettype none

package mem_fault_pkg;

    localparam int SEG_LIM_W = 20;

    // Low two bits are produced by this stage
    // bits 3:2 travel with the instruction
    typedef enum logic [3:0] {
        IE_NONE = 4'b0000,
        IE_PROT = 4'b0001,
        IE_PAGE = 4'b0010
    } ie_type_e;

    // Bits this stage owns
    localparam logic [3:0] IE_LOCAL_MASK = IE_PROT | IE_PAGE;

endpackage

`default_nettype wire

// ==== common/dmem_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dmem_port_if;
    import mem_stage_pkg::*;

    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0] rd_data;

    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    opsize_e           wr_size;

    modport ctrl (
        output rd_en, rd_addr, wr_en, wr_addr, wr_data, wr_size,
        input  rd_data
    );

    modport mem (
        input  rd_en, rd_addr, wr_en, wr_addr, wr_data, wr_size,
        output rd_data
    );

endinterface

`default_nettype wire

// ==== data_mem/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic      clk,
    input  logic      rst_n,
    dmem_port_if.mem  port
);
    import mem_stage_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [IDX_W-1:0]  rd_idx;
    logic [IDX_W-1:0]  wr_idx;
    logic [2:0]        wr_off;
    logic [7:0]        size_mask;
    logic [7:0]        byte_en;
    logic [DATA_W-1:0] wr_shifted;

    // Word index sits above the byte offset
    assign rd_idx = port.rd_addr[IDX_W+2:3];
    assign wr_idx = port.wr_addr[IDX_W+2:3];
    assign wr_off = port.wr_addr[2:0];

    assign size_mask = 8'((9'h1 << size_bytes(port.wr_size)) - 9'h1);
    assign byte_en   = size_mask << wr_off;

    // Low bytes of the write data land on the lanes starting at the offset
    assign wr_shifted = port.wr_data << {wr_off, 3'b000};

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            for (int b = 0; b < 8; b++) begin
                if (byte_en[b]) begin
                    mem[wr_idx][b*8 +: 8] <= wr_shifted[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, returns the word as it was before this edge's write
    always_ff @(posedge clk) begin
        if (port.rd_en) begin
            port.rd_data <= mem[rd_idx];
        end
    end

    a_no_word_cross: assert property (@(posedge clk) disable iff (!rst_n)
        port.wr_en |-> (({1'b0, wr_off} + size_bytes(port.wr_size)) <= 4'd8));

endmodule

`default_nettype wire

// ==== verilog/seg_limit_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg_limit_check (
    input  logic [mem_stage_pkg::ADDR_W-1:0]    mem_addr1_end,
    input  logic [mem_stage_pkg::ADDR_W-1:0]    mem_addr2_end,
    input  logic [mem_fault_pkg::SEG_LIM_W-1:0] seg1_lim,
    input  logic [mem_fault_pkg::SEG_LIM_W-1:0] seg2_lim,
    input  logic [1:0]                          mem1_rw,
    input  logic [1:0]                          mem2_rw,
    output logic                                seg_fault1,
    output logic                                seg_fault2
);
    import mem_stage_pkg::*;
    import mem_fault_pkg::*;

    // Only an operand that is accessed can fault
    function automatic logic over_limit(
        input logic [1:0]           rw,
        input logic [ADDR_W-1:0]    addr_end,
        input logic [SEG_LIM_W-1:0] lim
    );
        logic [ADDR_W-1:0] lim_ext;
        lim_ext = ADDR_W'(lim);
        return (rw != 2'b00) && (addr_end > lim_ext);
    endfunction

    assign seg_fault1 = over_limit(mem1_rw, mem_addr1_end, seg1_lim);
    assign seg_fault2 = over_limit(mem2_rw, mem_addr2_end, seg2_lim);

endmodule

`default_nettype wire

// ==== verilog/operand_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_router #(
    parameter int NUM_OPS = 2
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  lat_load,
    input  logic [(1 << mem_stage_pkg::REG_IDX_W)-1:0][mem_stage_pkg::DATA_W-1:0] regs,
    input  logic [15:0]                           seg1,
    input  logic [15:0]                           seg2,
    input  logic [15:0]                           seg3,
    input  logic [15:0]                           seg4,
    input  logic [mem_stage_pkg::ADDR_W-1:0]      mem_addr2,
    input  logic [mem_stage_pkg::ADDR_W-1:0]      eip_in,
    input  logic [mem_stage_pkg::DATA_W-1:0]      imm,
    input  mem_stage_pkg::op_src_e [NUM_OPS-1:0]  op_sel,
    input  logic [NUM_OPS-1:0][mem_stage_pkg::REG_IDX_W-1:0] op_idx,
    input  mem_stage_pkg::dest_kind_e             dest_sel,
    input  logic [mem_stage_pkg::REG_IDX_W-1:0]   dest_idx,
    input  logic [mem_stage_pkg::DATA_W-1:0]      mem_data,
    output logic [NUM_OPS-1:0][mem_stage_pkg::DATA_W-1:0] op_val,
    output logic [mem_stage_pkg::ADDR_W-1:0]      dest_addr,
    output mem_stage_pkg::dest_kind_e             dest_kind
);
    import mem_stage_pkg::*;

    logic [(1 << REG_IDX_W)-1:0][DATA_W-1:0] regs_q;
    logic [3:0][15:0]                        segs_q;
    logic [ADDR_W-1:0]                       mem_addr2_q;
    logic [ADDR_W-1:0]                       eip_q;
    logic [DATA_W-1:0]                       imm_q;
    op_src_e [NUM_OPS-1:0]                   op_sel_q;
    logic [NUM_OPS-1:0][REG_IDX_W-1:0]       op_idx_q;
    dest_kind_e                              dest_sel_q;
    logic [REG_IDX_W-1:0]                    dest_idx_q;

    // Selects come up as none so nothing is routed before the first load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_OPS; i++) begin
                op_sel_q[i] <= SRC_NONE;
            end
            dest_sel_q <= DEST_NONE;
        end else if (lat_load) begin
            op_sel_q   <= op_sel;
            dest_sel_q <= dest_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (lat_load) begin
            regs_q      <= regs;
            segs_q      <= {seg4, seg3, seg2, seg1};
            mem_addr2_q <= mem_addr2;
            eip_q       <= eip_in;
            imm_q       <= imm;
            op_idx_q    <= op_idx;
            dest_idx_q  <= dest_idx;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_OPS; i++) begin
            case (op_sel_q[i])
                SRC_REG:  op_val[i] = regs_q[op_idx_q[i]];
                SRC_SEG:  op_val[i] = DATA_W'(segs_q[op_idx_q[i]]);
                SRC_MEM1: op_val[i] = mem_data;
                SRC_EIP:  op_val[i] = DATA_W'(eip_q);
                SRC_IMM:  op_val[i] = imm_q;
                default:  op_val[i] = '0;
            endcase
        end
    end

    assign dest_addr = (dest_sel_q == DEST_MEM) ? mem_addr2_q : ADDR_W'(dest_idx_q);
    assign dest_kind = dest_sel_q;

endmodule

`default_nettype wire

// ==== verilog/mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// mem*_rw: bit 0 is a read, bit 1 a write
module mem_ctrl #(
    parameter int MEM_WORDS = 256
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             valid_in,
    input  logic                             fwd_stall,
    input  mem_stage_pkg::opsize_e           opsize_in,
    input  logic [3:0]                       memsize_ovr,
    input  logic [mem_stage_pkg::ADDR_W-1:0] mem_addr1,
    input  logic [mem_stage_pkg::ADDR_W-1:0] mem_addr2,
    input  logic [1:0]                       mem1_rw,
    input  logic [1:0]                       mem2_rw,
    input  logic                             ie_in,
    input  logic [3:0]                       ie_type_in,
    input  logic                             seg_fault1,
    input  logic                             seg_fault2,
    input  logic                             wb_valid,
    input  logic [mem_stage_pkg::ADDR_W-1:0] wb_addr,
    input  logic [mem_stage_pkg::DATA_W-1:0] wb_data,
    input  mem_stage_pkg::opsize_e           wb_size,
    output logic                             stall,
    output logic                             valid_out,
    output mem_stage_pkg::opsize_e           opsize_out,
    output logic                             ie_out,
    output logic [3:0]                       ie_type_out,
    output logic                             lat_load,
    dmem_port_if.ctrl                        dmem
);
    import mem_stage_pkg::*;
    import mem_fault_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    typedef enum logic {
        RUN  = 1'b0,
        HOLD = 1'b1
    } ctrl_state_e;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    opsize_e     size_sel;
    opsize_e     opsize_q;
    logic        hazard;
    logic        accept;
    logic        fault;
    ie_type_e    fault_type;
    logic        valid_q;
    logic        ie_q;
    logic [3:0]  ie_type_q;

    // Lowest set override bit wins
    always_comb begin
        if (memsize_ovr[0]) begin
            size_sel = SZ_BYTE;
        end else if (memsize_ovr[1]) begin
            size_sel = SZ_WORD;
        end else if (memsize_ovr[2]) begin
            size_sel = SZ_DWORD;
        end else if (memsize_ovr[3]) begin
            size_sel = SZ_QWORD;
        end else begin
            size_sel = opsize_in;
        end
    end

    // Read of the word being written back this cycle
    assign hazard = (state == RUN) && valid_in && mem1_rw[0] && wb_valid &&
                    (wb_addr[IDX_W+2:3] == mem_addr1[IDX_W+2:3]);
    assign stall    = hazard || fwd_stall;
    assign accept   = valid_in && !stall;
    assign lat_load = accept;

    always_comb begin
        state_nxt = state;
        case (state)
            RUN: begin
                if (hazard) begin
                    state_nxt = HOLD;
                end
            end
            HOLD: begin
                if (!fwd_stall) begin
                    state_nxt = RUN;
                end
            end
            default: state_nxt = RUN;
        endcase
    end

    assign dmem.rd_en   = accept && mem1_rw[0];
    assign dmem.rd_addr = mem_addr1;
    assign dmem.wr_en   = wb_valid;
    assign dmem.wr_addr = wb_addr;
    assign dmem.wr_data = wb_data;
    assign dmem.wr_size = wb_size;

    assign fault      = seg_fault1 || seg_fault2;
    assign fault_type = fault ? IE_PROT : IE_NONE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RUN;
            valid_q   <= 1'b0;
            ie_q      <= 1'b0;
            ie_type_q <= '0;
        end else begin
            state <= state_nxt;
            // hold the result while downstream pushes back
            if (!fwd_stall) begin
                valid_q <= accept;
            end
            if (accept) begin
                ie_q      <= ie_in || fault;
                ie_type_q <= (ie_type_in & ~IE_LOCAL_MASK) | fault_type;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opsize_q <= size_sel;
        end
    end

    assign valid_out   = valid_q && !fwd_stall;
    assign opsize_out  = opsize_q;
    assign ie_out      = ie_q && valid_out;
    assign ie_type_out = valid_out ? ie_type_q : '0;

    // Hazard hold lasts one cycle unless downstream also pushes back
    a_hold_once: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && !fwd_stall) |=> !(stall && !fwd_stall));

    a_no_valid_in_reset: assert property (@(posedge clk)
        !rst_n |-> !valid_out);

    // A store on operand 2 retires as one writeback and must fit in a word
    a_store_in_word: assert property (@(posedge clk) disable iff (!rst_n)
        (accept && mem2_rw[1]) |->
        (({1'b0, mem_addr2[2:0]} + size_bytes(size_sel)) <= 4'd8));

endmodule

`default_nettype wire

// ==== verilog/mem_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top #(
    parameter int MEM_WORDS = 256,
    parameter int NUM_OPS   = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   valid_in,
    input  logic                                   fwd_stall,
    input  mem_stage_pkg::opsize_e                 opsize_in,
    input  logic [3:0]                             memsize_ovr,
    input  logic [mem_stage_pkg::ADDR_W-1:0]       mem_addr1,
    input  logic [mem_stage_pkg::ADDR_W-1:0]       mem_addr2,
    input  logic [mem_stage_pkg::ADDR_W-1:0]       mem_addr1_end,
    input  logic [mem_stage_pkg::ADDR_W-1:0]       mem_addr2_end,
    input  logic [1:0]                             mem1_rw,
    input  logic [1:0]                             mem2_rw,
    input  logic [(1 << mem_stage_pkg::REG_IDX_W)-1:0][mem_stage_pkg::DATA_W-1:0] regs,
    input  logic [15:0]                            seg1,
    input  logic [15:0]                            seg2,
    input  logic [15:0]                            seg3,
    input  logic [15:0]                            seg4,
    input  logic [mem_fault_pkg::SEG_LIM_W-1:0]    seg1_lim,
    input  logic [mem_fault_pkg::SEG_LIM_W-1:0]    seg2_lim,
    input  mem_stage_pkg::op_src_e [NUM_OPS-1:0]   op_sel,
    input  logic [NUM_OPS-1:0][mem_stage_pkg::REG_IDX_W-1:0] op_idx,
    input  mem_stage_pkg::dest_kind_e              dest_sel,
    input  logic [mem_stage_pkg::REG_IDX_W-1:0]    dest_idx,
    input  logic [mem_stage_pkg::ADDR_W-1:0]       eip_in,
    input  logic [mem_stage_pkg::DATA_W-1:0]       imm,
    input  logic                                   ie_in,
    input  logic [3:0]                             ie_type_in,
    input  logic                                   wb_valid,
    input  logic [mem_stage_pkg::ADDR_W-1:0]       wb_addr,
    input  logic [mem_stage_pkg::DATA_W-1:0]       wb_data,
    input  mem_stage_pkg::opsize_e                 wb_size,
    output logic                                   valid_out,
    output logic                                   stall,
    output mem_stage_pkg::opsize_e                 opsize_out,
    output logic [NUM_OPS-1:0][mem_stage_pkg::DATA_W-1:0] op_val,
    output logic [mem_stage_pkg::ADDR_W-1:0]       dest_addr,
    output mem_stage_pkg::dest_kind_e              dest_kind,
    output logic                                   ie_out,
    output logic [3:0]                             ie_type_out
);

    logic seg_fault1;
    logic seg_fault2;
    logic lat_load;

    dmem_port_if dmem_if ();

    mem_ctrl #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (valid_in),
        .fwd_stall   (fwd_stall),
        .opsize_in   (opsize_in),
        .memsize_ovr (memsize_ovr),
        .mem_addr1   (mem_addr1),
        .mem_addr2   (mem_addr2),
        .mem1_rw     (mem1_rw),
        .mem2_rw     (mem2_rw),
        .ie_in       (ie_in),
        .ie_type_in  (ie_type_in),
        .seg_fault1  (seg_fault1),
        .seg_fault2  (seg_fault2),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .wb_size     (wb_size),
        .stall       (stall),
        .valid_out   (valid_out),
        .opsize_out  (opsize_out),
        .ie_out      (ie_out),
        .ie_type_out (ie_type_out),
        .lat_load    (lat_load),
        .dmem        (dmem_if.ctrl)
    );

    operand_router #(
        .NUM_OPS (NUM_OPS)
    ) u_router (
        .clk       (clk),
        .rst_n     (rst_n),
        .lat_load  (lat_load),
        .regs      (regs),
        .seg1      (seg1),
        .seg2      (seg2),
        .seg3      (seg3),
        .seg4      (seg4),
        .mem_addr2 (mem_addr2),
        .eip_in    (eip_in),
        .imm       (imm),
        .op_sel    (op_sel),
        .op_idx    (op_idx),
        .dest_sel  (dest_sel),
        .dest_idx  (dest_idx),
        .mem_data  (dmem_if.rd_data),
        .op_val    (op_val),
        .dest_addr (dest_addr),
        .dest_kind (dest_kind)
    );

    seg_limit_check u_seg_check (
        .mem_addr1_end (mem_addr1_end),
        .mem_addr2_end (mem_addr2_end),
        .seg1_lim      (seg1_lim),
        .seg2_lim      (seg2_lim),
        .mem1_rw       (mem1_rw),
        .mem2_rw       (mem2_rw),
        .seg_fault1    (seg_fault1),
        .seg_fault2    (seg_fault2)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_dmem (
        .clk   (clk),
        .rst_n (rst_n),
        .port  (dmem_if.mem)
    );

endmodule

`default_nettype wire

// ==== tb/mem_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;
    import mem_stage_pkg::*;
    import mem_fault_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int NUM_OPS   = 2;
    localparam int IDX_W     = $clog2(MEM_WORDS);
    localparam int MAX_WAIT  = 40;

    typedef struct packed {
        logic [1:0]              size;
        logic [3:0]              ovr;
        logic [ADDR_W-1:0]       addr1;
        logic [ADDR_W-1:0]       addr2;
        logic [ADDR_W-1:0]       end1;
        logic [ADDR_W-1:0]       end2;
        logic [1:0]              rw1;
        logic [1:0]              rw2;
        logic [3:0][DATA_W-1:0]  regs;
        logic [3:0][15:0]        segs;
        logic [SEG_LIM_W-1:0]    lim1;
        logic [SEG_LIM_W-1:0]    lim2;
        logic [NUM_OPS-1:0][2:0] sel;
        logic [NUM_OPS-1:0][1:0] idx;
        logic [1:0]              dsel;
        logic [1:0]              didx;
        logic [ADDR_W-1:0]       eip;
        logic [DATA_W-1:0]       imm;
        logic                    ie;
        logic [3:0]              ie_type;
    } instr_t;

    typedef struct packed {
        logic [NUM_OPS-1:0][DATA_W-1:0] ops;
        logic [ADDR_W-1:0]              dest_addr;
        logic [1:0]                     dest_kind;
        logic [1:0]                     size;
        logic                           ie;
        logic [3:0]                     ie_type;
    } result_t;

    logic                             clk;
    logic                             rst_n;
    logic                             valid_in;
    logic                             fwd_stall;
    opsize_e                          opsize_in;
    logic [3:0]                       memsize_ovr;
    logic [ADDR_W-1:0]                mem_addr1;
    logic [ADDR_W-1:0]                mem_addr2;
    logic [ADDR_W-1:0]                mem_addr1_end;
    logic [ADDR_W-1:0]                mem_addr2_end;
    logic [1:0]                       mem1_rw;
    logic [1:0]                       mem2_rw;
    logic [3:0][DATA_W-1:0]           regs;
    logic [15:0]                      seg1;
    logic [15:0]                      seg2;
    logic [15:0]                      seg3;
    logic [15:0]                      seg4;
    logic [SEG_LIM_W-1:0]             seg1_lim;
    logic [SEG_LIM_W-1:0]             seg2_lim;
    op_src_e [NUM_OPS-1:0]            op_sel;
    logic [NUM_OPS-1:0][1:0]          op_idx;
    dest_kind_e                       dest_sel;
    logic [1:0]                       dest_idx;
    logic [ADDR_W-1:0]                eip_in;
    logic [DATA_W-1:0]                imm;
    logic                             ie_in;
    logic [3:0]                       ie_type_in;
    logic                             wb_valid;
    logic [ADDR_W-1:0]                wb_addr;
    logic [DATA_W-1:0]                wb_data;
    opsize_e                          wb_size;
    logic                             valid_out;
    logic                             stall;
    opsize_e                          opsize_out;
    logic [NUM_OPS-1:0][DATA_W-1:0]   op_val;
    logic [ADDR_W-1:0]                dest_addr;
    dest_kind_e                       dest_kind;
    logic                             ie_out;
    logic [3:0]                       ie_type_out;

    logic [DATA_W-1:0] shadow [MEM_WORDS];
    result_t           exp_q [$];
    logic [31:0]       lcg_state = 32'd52569;
    string             test_name = "init";

    mem_stage_top #(
        .MEM_WORDS (MEM_WORDS),
        .NUM_OPS   (NUM_OPS)
    ) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rnd(input int unsigned n);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) % n;
    endfunction

    function automatic logic [31:0] rand32();
        logic [31:0] hi;
        hi = rnd(32'h10000);
        return {hi[15:0], 16'(rnd(32'h10000))};
    endfunction

    function automatic logic [DATA_W-1:0] rand64();
        return {rand32(), rand32()};
    endfunction

    function automatic logic [IDX_W-1:0] word_of(input logic [ADDR_W-1:0] addr);
        return addr[IDX_W+2:3];
    endfunction

    // Preload pattern mixes every bit of the word index
    function automatic logic [DATA_W-1:0] fill_word(input int idx);
        logic [31:0] a;
        a = 32'(idx);
        return {a * 32'h9e3779b1, ~(a * 32'h85ebca6b)};
    endfunction

    function automatic result_t ref_result(input instr_t in, input logic [DATA_W-1:0] mem_word);
        result_t r;
        logic    f1;
        logic    f2;
        int      i;
        if (in.ovr[0]) r.size = 2'd0;
        else if (in.ovr[1]) r.size = 2'd1;
        else if (in.ovr[2]) r.size = 2'd2;
        else if (in.ovr[3]) r.size = 2'd3;
        else r.size = in.size;
        for (i = 0; i < NUM_OPS; i++) begin
            case (in.sel[i])
                SRC_REG:  r.ops[i] = in.regs[in.idx[i]];
                SRC_SEG:  r.ops[i] = {48'h0, in.segs[in.idx[i]]};
                SRC_MEM1: r.ops[i] = mem_word;
                SRC_EIP:  r.ops[i] = {32'h0, in.eip};
                SRC_IMM:  r.ops[i] = in.imm;
                default:  r.ops[i] = '0;
            endcase
        end
        r.dest_addr = (in.dsel == DEST_MEM) ? in.addr2 : {30'h0, in.didx};
        r.dest_kind = in.dsel;
        f1 = (in.rw1 != 2'b00) && (in.end1 > {12'h0, in.lim1});
        f2 = (in.rw2 != 2'b00) && (in.end2 > {12'h0, in.lim2});
        r.ie      = in.ie | f1 | f2;
        r.ie_type = {in.ie_type[3:2], 1'b0, f1 | f2};
        return r;
    endfunction

    function automatic instr_t rand_instr();
        instr_t      in;
        int          i;
        logic [31:0] k;
        k = rnd(5);
        in.ovr   = (k == 4) ? 4'b0000 : 4'(1 << k);
        in.size  = 2'(rnd(4));
        in.addr1 = rnd(MEM_WORDS * 8);
        // Stores on operand 2 stay inside one word
        in.addr2 = rnd(MEM_WORDS) << 3;
        in.lim1  = 20'(rand32());
        in.lim2  = 20'(rand32());
        in.end1  = {12'h0, in.lim1} + rnd(5) - 32'd2;
        in.end2  = {12'h0, in.lim2} + rnd(5) - 32'd2;
        in.rw1   = 2'(rnd(4));
        in.rw2   = 2'(rnd(4));
        for (i = 0; i < 4; i++) begin
            in.regs[i] = rand64();
            in.segs[i] = 16'(rnd(32'h10000));
        end
        for (i = 0; i < NUM_OPS; i++) begin
            in.sel[i] = 3'(rnd(6));
            in.idx[i] = 2'(rnd(4));
            if (in.sel[i] == SRC_MEM1) begin
                in.rw1[0] = 1'b1;
            end
        end
        in.dsel    = 2'(rnd(4));
        in.didx    = 2'(rnd(4));
        in.eip     = rand32();
        in.imm     = rand64();
        in.ie      = (rnd(4) == 0);
        in.ie_type = 4'(rnd(16));
        return in;
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_val(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %0h actual %0h", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic timeout(input string what);
        $display("Timed out waiting for %s in test %s", what, test_name);
        abort_run();
    endtask

    task automatic shadow_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                                input logic [1:0] size);
        int b;
        int off;
        off = addr[2:0];
        for (b = 0; b < (1 << size); b++) begin
            shadow[word_of(addr)][(off + b) * 8 +: 8] = data[b * 8 +: 8];
        end
    endtask

    task automatic drive_instr(input instr_t in);
        int i;
        opsize_in     = opsize_e'(in.size);
        memsize_ovr   = in.ovr;
        mem_addr1     = in.addr1;
        mem_addr2     = in.addr2;
        mem_addr1_end = in.end1;
        mem_addr2_end = in.end2;
        mem1_rw       = in.rw1;
        mem2_rw       = in.rw2;
        regs          = in.regs;
        seg1          = in.segs[0];
        seg2          = in.segs[1];
        seg3          = in.segs[2];
        seg4          = in.segs[3];
        seg1_lim      = in.lim1;
        seg2_lim      = in.lim2;
        for (i = 0; i < NUM_OPS; i++) begin
            op_sel[i] = op_src_e'(in.sel[i]);
            op_idx[i] = in.idx[i];
        end
        dest_sel   = dest_kind_e'(in.dsel);
        dest_idx   = in.didx;
        eip_in     = in.eip;
        imm        = in.imm;
        ie_in      = in.ie;
        ie_type_in = in.ie_type;
    endtask

    task automatic write_back(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [1:0] size);
        wb_valid = 1'b1;
        wb_addr  = addr;
        wb_data  = data;
        wb_size  = opsize_e'(size);
        @(negedge clk);
        shadow_write(addr, data, size);
        @(posedge clk);
        #1;
        wb_valid = 1'b0;
    endtask

    // Holds the instruction until accepted
    // The writeback lasts one cycle
    task automatic issue(input instr_t in, input logic wbv, input logic [ADDR_W-1:0] wba,
                         input logic [DATA_W-1:0] wbd, input logic [1:0] wbs,
                         output int stalls);
        int   waited;
        logic done;
        stalls = 0;
        waited = 0;
        done   = 1'b0;
        drive_instr(in);
        valid_in = 1'b1;
        wb_valid = wbv;
        wb_addr  = wba;
        wb_data  = wbd;
        wb_size  = opsize_e'(wbs);
        while (!done) begin
            @(negedge clk);
            if (stall) begin
                stalls++;
            end else begin
                exp_q.push_back(ref_result(in, shadow[word_of(in.addr1)]));
                done = 1'b1;
            end
            if (wb_valid) begin
                shadow_write(wb_addr, wb_data, wb_size);
            end
            @(posedge clk);
            #1;
            wb_valid = 1'b0;
            waited++;
            if (!done && waited > MAX_WAIT) begin
                timeout("instruction accept");
            end
        end
        valid_in = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > MAX_WAIT) begin
                timeout("outstanding results");
            end
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic check_idle();
        @(negedge clk);
        check_val("valid_out idle", 0, valid_out);
        check_val("ie_out idle", 0, ie_out);
        check_val("stall idle", 0, stall);
        check_val("ie_type_out idle", 0, ie_type_out);
        @(posedge clk);
        #1;
    endtask

    // Compares every result leaving the stage
    initial begin
        result_t e;
        forever begin
            @(negedge clk);
            if (fwd_stall && rst_n) begin
                check_val("stall under fwd_stall", 1, stall);
                check_val("valid_out under fwd_stall", 0, valid_out);
            end
            if (valid_out === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("valid_out high with no instruction outstanding in %s", test_name);
                    abort_run();
                end
                e = exp_q.pop_front();
                check_val("op_val[0]", e.ops[0], op_val[0]);
                check_val("op_val[1]", e.ops[1], op_val[1]);
                check_val("dest_addr", e.dest_addr, dest_addr);
                check_val("dest_kind", e.dest_kind, dest_kind);
                check_val("opsize_out", e.size, opsize_out);
                check_val("ie_out", e.ie, ie_out);
                check_val("ie_type_out", e.ie_type, ie_type_out);
            end
        end
    end

    initial begin
        instr_t            in;
        int                stalls;
        int                i;
        int                s;
        logic [ADDR_W-1:0] a;
        rst_n     = 1'b0;
        valid_in  = 1'b0;
        fwd_stall = 1'b0;
        wb_valid  = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        wb_size   = SZ_BYTE;
        drive_instr('0);

        test_name = "reset";
        apply_reset();
        check_idle();

        test_name = "preload";
        for (i = 0; i < MEM_WORDS; i++) begin
            write_back(32'(i * 8), fill_word(i), SZ_QWORD);
        end

        test_name = "routing";
        for (i = 0; i < 80; i++) begin
            in = rand_instr();
            s  = rnd(4);
            a  = rnd(MEM_WORDS * 8) & ~((1 << s) - 1);
            issue(in, rnd(2) == 1, a, rand64(), 2'(s), stalls);
        end

        test_name = "size_override";
        for (i = 0; i < 5; i++) begin
            for (s = 0; s < 4; s++) begin
                in      = rand_instr();
                in.ovr  = (i == 4) ? 4'b0000 : 4'(1 << i);
                in.size = 2'(s);
                issue(in, 1'b0, '0, '0, 2'd0, stalls);
            end
        end
        for (i = 0; i < 8; i++) begin
            in     = rand_instr();
            in.ovr = 4'(rnd(16));
            issue(in, 1'b0, '0, '0, 2'd0, stalls);
        end

        test_name = "seg_limit";
        for (s = 0; s < 4; s++) begin
            for (i = 0; i < 3; i++) begin
                in        = rand_instr();
                in.rw1    = 2'(s);
                in.rw2    = 2'(3 - s);
                in.end1   = {12'h0, in.lim1} + 32'(i) - 32'd1;
                in.end2   = {12'h0, in.lim2} + 32'd1 - 32'(i);
                in.ie     = 1'b0;
                in.sel[0] = SRC_IMM;
                in.sel[1] = SRC_EIP;
                issue(in, 1'b0, '0, '0, 2'd0, stalls);
            end
        end

        test_name = "wb_read";
        for (s = 0; s < 4; s++) begin
            for (i = 0; i < 4; i++) begin
                a = rnd(MEM_WORDS * 8) & ~((1 << s) - 1);
                write_back(a, rand64(), 2'(s));
                in        = rand_instr();
                in.addr1  = a;
                in.rw1[0] = 1'b1;
                in.sel[0] = SRC_MEM1;
                issue(in, 1'b0, '0, '0, 2'd0, stalls);
            end
        end

        test_name = "hazard";
        for (s = 0; s < 4; s++) begin
            for (i = 0; i < 3; i++) begin
                a         = rnd(MEM_WORDS * 8) & ~((1 << s) - 1);
                in        = rand_instr();
                in.addr1  = {a[ADDR_W-1:3], 3'(rnd(8))};
                in.rw1[0] = 1'b1;
                in.sel[1] = SRC_MEM1;
                issue(in, 1'b1, a, rand64(), 2'(s), stalls);
                check_val("hazard stall cycles", 1, stalls);
            end
        end

        test_name = "backpressure";
        for (i = 0; i < 4; i++) begin
            issue(rand_instr(), 1'b0, '0, '0, 2'd0, stalls);
            fwd_stall = 1'b1;
            fork
                issue(rand_instr(), 1'b0, '0, '0, 2'd0, stalls);
                begin
                    repeat (6) @(posedge clk);
                    #1;
                    fwd_stall = 1'b0;
                end
            join
            check_val("stall cycles under fwd_stall", 6, stalls);
        end
        wait_drain();

        // Reset drops the result still in the output register
        test_name = "reset_after_run";
        in    = rand_instr();
        in.ie = 1'b1;
        issue(in, 1'b0, '0, '0, 2'd0, stalls);
        exp_q.delete();
        apply_reset();
        check_idle();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
common/mem_stage_pkg.sv
common/mem_fault_pkg.sv
common/dmem_port_if.sv
data_mem/data_mem.sv
verilog/seg_limit_check.sv
verilog/operand_router.sv
verilog/mem_ctrl.sv
verilog/mem_stage_top.sv
tb/mem_stage_tb.sv
